// ==== rooth_params.svh ====
/*
 * global sizes for the rooth pipeline-control slice
 *   data and address width
 *   instruction width
 *   pc value after reset
 */

`ifndef ROOTH_PARAMS_SVH
`define ROOTH_PARAMS_SVH

// --------------------
// widths
// --------------------
`define CPU_WIDTH  32   // data and address bus
`define INST_WIDTH 32   // one rv32i instruction

// --------------------
// reset values
// --------------------
`define RESET_PC   32'h0000_0000

`endif

// ==== rooth_pkg.sv ====
/*
 * shared types for the pipeline-control slice
 *   flow_e      per-stage action (work, stop, refresh)
 *   branch_e    conditional branch kinds
 *   jump_e      unconditional control transfers
 *   fetch_pkt_t payload of the fetch-to-decode register
 *   exec_pkt_t  payload of the decode-to-execute register
 */

`include "rooth_params.svh"

package rooth_pkg;

    // --------------------
    // stage actions
    // --------------------
    typedef enum logic [1:0] {
        FLOW_WORK    = 2'd0,    // load next value
        FLOW_STOP    = 2'd1,    // hold contents
        FLOW_REFRESH = 2'd2     // load a bubble
    } flow_e;

    // --------------------
    // control transfers
    // --------------------
    typedef enum logic [2:0] {
        BRANCH_NONE = 3'd0,
        BRANCH_BEQ  = 3'd1,
        BRANCH_BNE  = 3'd2,
        BRANCH_BLT  = 3'd3,
        BRANCH_BGE  = 3'd4,
        BRANCH_BLTU = 3'd5,
        BRANCH_BGEU = 3'd6
    } branch_e;

    typedef enum logic [1:0] {
        JUMP_NONE  = 2'd0,
        JUMP_JAL   = 2'd1,
        JUMP_JALR  = 2'd2,
        JUMP_FENCE = 2'd3       // refetch from pc + 4
    } jump_e;

    // --------------------
    // stage payloads
    // --------------------
    typedef struct packed {
        logic                   valid;
        logic [`CPU_WIDTH-1:0]  pc;
        logic [`INST_WIDTH-1:0] inst;
    } fetch_pkt_t;

    // all zeros is a bubble, no branch and no jump
    typedef struct packed {
        logic                  valid;
        logic [`CPU_WIDTH-1:0] pc;
        branch_e               branch;
        jump_e                 jump;
        logic [`CPU_WIDTH-1:0] imm;
        logic [`CPU_WIDTH-1:0] rs1;
        logic [`CPU_WIDTH-1:0] rs2;
    } exec_pkt_t;

endpackage

// ==== branch_cmp.sv ====
/*
 * execute-stage branch comparator
 *   equality flag for beq and bne
 *   signed less / more-or-equal for blt and bge
 *   unsigned less / more-or-equal for bltu and bgeu
 */

`include "rooth_params.svh"

module branch_cmp import rooth_pkg::*; (
    input  logic [`CPU_WIDTH-1:0] rs1_i,
    input  logic [`CPU_WIDTH-1:0] rs2_i,
    input  branch_e               branch_i,
    output logic                  zero_o,       // operands equal
    output logic                  more_zero_o,  // rs1 >= rs2
    output logic                  less_o        // rs1 < rs2
);

    logic lt_signed;
    logic lt_unsigned;

    // --------------------
    // raw compares
    // --------------------
    assign lt_signed   = $signed(rs1_i) < $signed(rs2_i);
    assign lt_unsigned = rs1_i < rs2_i;

    assign zero_o = (rs1_i == rs2_i);

    // pick signedness from the branch kind
    always_comb begin
        less_o      = 1'b0;
        more_zero_o = 1'b0;
        case (branch_i)
            BRANCH_BLT,
            BRANCH_BGE: begin
                less_o      = lt_signed;
                more_zero_o = !lt_signed;
            end
            BRANCH_BLTU,
            BRANCH_BGEU: begin
                less_o      = lt_unsigned;
                more_zero_o = !lt_unsigned;
            end
            default: begin
                // beq / bne only look at zero
                less_o      = 1'b0;
                more_zero_o = 1'b0;
            end
        endcase
    end

endmodule

// ==== flow_ctrl.sv ====
/*
 * pipeline flow controller
 *   ranks interrupt, holds, stalls, branches, jumps and jtag halt
 *   drives the next pc and the pc-select flag
 *   drives one action per stage: pc, de, ex, as, wb
 */

`include "rooth_params.svh"

module flow_ctrl import rooth_pkg::*; (
    input  logic                  jtag_halt_flag_i,
    input  logic                  bus_wait_i,          // fetch bus not ready
    input  logic                  alu_busy_i,          // divider busy
    input  logic                  access_mem_hold_i,
    input  logic                  pr_access_mem_flag_i,
    input  logic                  client_hold_flag_i,
    input  logic                  client_int_assert_i,
    input  logic                  zero_i,
    input  logic                  more_zero_i,
    input  logic                  less_i,
    input  branch_e               branch_i,
    input  jump_e                 jump_i,
    input  logic [`CPU_WIDTH-1:0] pc_adder_i,          // execute pc
    input  logic [`CPU_WIDTH-1:0] imm_i,
    input  logic [`CPU_WIDTH-1:0] reg1_rd_data_i,      // rs1 for jalr
    input  logic [`CPU_WIDTH-1:0] client_int_addr_i,   // interrupt entry
    output logic [`CPU_WIDTH-1:0] next_pc_o,
    output logic                  next_pc_four_o,      // 1: fetch pc + 4
    output flow_e                 flow_pc_o,
    output flow_e                 flow_de_o,
    output flow_e                 flow_ex_o,
    output flow_e                 flow_as_o,
    output flow_e                 flow_wb_o
);

    logic [`CPU_WIDTH-1:0] rel_target;   // pc relative
    logic [`CPU_WIDTH-1:0] reg_target;   // jalr, no low-bit clear
    logic [`CPU_WIDTH-1:0] seq_target;   // fence refetch
    logic                  br_taken;

    assign rel_target = pc_adder_i + imm_i;
    assign reg_target = reg1_rd_data_i + imm_i;
    assign seq_target = pc_adder_i + `CPU_WIDTH'd4;

    // --------------------
    // branch condition
    // --------------------
    always_comb begin
        case (branch_i)
            BRANCH_BEQ:  br_taken = zero_i;
            BRANCH_BNE:  br_taken = !zero_i;
            BRANCH_BLT,
            BRANCH_BLTU: br_taken = less_i;
            BRANCH_BGE,
            BRANCH_BGEU: br_taken = more_zero_i;
            default:     br_taken = 1'b0;
        endcase
    end

    // --------------------
    // priority resolution
    // --------------------
    always_comb begin
        // defaults: everything flows, sequential fetch
        next_pc_o      = rel_target;
        next_pc_four_o = 1'b1;
        flow_pc_o      = FLOW_WORK;
        flow_de_o      = FLOW_WORK;
        flow_ex_o      = FLOW_WORK;
        flow_as_o      = FLOW_WORK;
        flow_wb_o      = FLOW_WORK;

        if (client_int_assert_i) begin
            next_pc_o      = client_int_addr_i;
            next_pc_four_o = 1'b0;
            flow_de_o      = FLOW_REFRESH;
            flow_ex_o      = FLOW_REFRESH;
            flow_as_o      = FLOW_REFRESH;
            flow_wb_o      = FLOW_REFRESH;
        end else if (client_hold_flag_i) begin
            flow_pc_o = FLOW_STOP;
            flow_de_o = FLOW_STOP;
            flow_ex_o = FLOW_STOP;
            flow_as_o = FLOW_STOP;
            flow_wb_o = FLOW_STOP;
        end else if (access_mem_hold_i) begin
            flow_pc_o = FLOW_STOP;
            flow_de_o = FLOW_STOP;
            flow_ex_o = FLOW_STOP;
            flow_as_o = FLOW_STOP;
            flow_wb_o = FLOW_REFRESH;     // drain writeback
        end else if (pr_access_mem_flag_i) begin
            flow_pc_o = FLOW_STOP;
            flow_de_o = FLOW_STOP;
            flow_ex_o = FLOW_REFRESH;
        end else if (alu_busy_i) begin
            flow_pc_o = FLOW_STOP;
            flow_de_o = FLOW_STOP;
            flow_ex_o = FLOW_STOP;
            flow_as_o = FLOW_REFRESH;
        end else if (bus_wait_i) begin
            flow_pc_o = FLOW_STOP;
            flow_de_o = FLOW_REFRESH;     // no valid fetch yet
        end else if (branch_i != BRANCH_NONE) begin
            if (br_taken) begin
                next_pc_o      = rel_target;
                next_pc_four_o = 1'b0;
                flow_de_o      = FLOW_REFRESH;
                flow_ex_o      = FLOW_REFRESH;
            end
        end else if (jump_i != JUMP_NONE) begin
            next_pc_four_o = 1'b0;
            flow_de_o      = FLOW_REFRESH;
            flow_ex_o      = FLOW_REFRESH;
            case (jump_i)
                JUMP_JAL:   next_pc_o = rel_target;
                JUMP_JALR:  next_pc_o = reg_target;
                JUMP_FENCE: next_pc_o = seq_target;
                default:    next_pc_four_o = 1'b1;
            endcase
        end else if (jtag_halt_flag_i) begin
            // halt ranks below control transfers
            flow_pc_o = FLOW_STOP;
            flow_de_o = FLOW_STOP;
            flow_ex_o = FLOW_STOP;
            flow_as_o = FLOW_STOP;
            flow_wb_o = FLOW_STOP;
        end
    end

endmodule

// ==== pc_reg.sv ====
/*
 * fetch program counter
 *   resets to the boot address
 *   advances by 4 or takes the redirect target under work
 *   holds under stop
 */

`include "rooth_params.svh"

module pc_reg import rooth_pkg::*; (
    input  logic                  clk_i,
    input  logic                  arst_n_i,
    input  flow_e                 flow_pc_i,
    input  logic                  next_pc_four_i,  // sequential fetch
    input  logic [`CPU_WIDTH-1:0] next_pc_i,       // redirect target
    output logic [`CPU_WIDTH-1:0] pc_o
);

    logic [`CPU_WIDTH-1:0] pc_q;
    logic [`CPU_WIDTH-1:0] pc_d;

    // --------------------
    // next pc select
    // --------------------
    assign pc_d = next_pc_four_i ? (pc_q + `CPU_WIDTH'd4) : next_pc_i;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pc_q <= `RESET_PC;
        end else if (flow_pc_i == FLOW_WORK) begin
            pc_q <= pc_d;
        end
        // stop holds, refresh never reaches the pc
    end

    assign pc_o = pc_q;

    // redirect targets from the controller must keep fetch word aligned
    pc_aligned_a: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        pc_o[1:0] == 2'b00
    ) else $error("pc_reg: pc 0x%08h not word aligned", pc_o);

endmodule

// ==== pipe_stage.sv ====
/*
 * pipeline stage register, generic over its payload
 *   work    load the upstream payload
 *   stop    keep the current payload
 *   refresh load an all-zero bubble
 */

module pipe_stage import rooth_pkg::*; #(
    parameter type payload_t = logic
) (
    input  logic     clk_i,
    input  logic     arst_n_i,
    input  flow_e    flow_i,
    input  payload_t data_i,
    output payload_t data_o
);

    payload_t data_q;

    // --------------------
    // stage register
    // --------------------
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            data_q <= payload_t'('0);    // bubble out of reset
        end else begin
            case (flow_i)
                FLOW_WORK:    data_q <= data_i;
                FLOW_REFRESH: data_q <= payload_t'('0);
                default:      data_q <= data_q;     // stop
            endcase
        end
    end

    assign data_o = data_q;

    // the controller decodes every stage action from live requests,
    // an unknown request level upstream would show up here
    flow_known_a: assert property (
        @(posedge clk_i) disable iff (!arst_n_i)
        !$isunknown(flow_i)
    ) else $error("pipe_stage: stage action is unknown");

endmodule

// ==== flow_top.sv ====
/*
 * pipeline-control slice top level
 *   pc register and fetch packet
 *   fetch-to-decode and decode-to-execute stage registers
 *   execute branch comparator
 *   flow controller driving all stage actions
 */

`include "rooth_params.svh"

module flow_top import rooth_pkg::*; (
    input  logic                   clk_i,
    input  logic                   arst_n_i,
    input  logic [`INST_WIDTH-1:0] fetch_inst_i,
    // decoded fields for the instruction in decode
    input  branch_e                de_branch_i,
    input  jump_e                  de_jump_i,
    input  logic [`CPU_WIDTH-1:0]  de_imm_i,
    input  logic [`CPU_WIDTH-1:0]  de_rs1_i,
    input  logic [`CPU_WIDTH-1:0]  de_rs2_i,
    // request levels
    input  logic                   jtag_halt_flag_i,
    input  logic                   bus_wait_i,
    input  logic                   alu_busy_i,
    input  logic                   access_mem_hold_i,
    input  logic                   pr_access_mem_flag_i,
    input  logic                   client_hold_flag_i,
    input  logic                   client_int_assert_i,
    input  logic [`CPU_WIDTH-1:0]  client_int_addr_i,
    // observed state
    output logic [`CPU_WIDTH-1:0]  pc_o,
    output logic                   de_valid_o,
    output logic [`CPU_WIDTH-1:0]  de_pc_o,
    output logic [`INST_WIDTH-1:0] de_inst_o,
    output logic                   ex_valid_o,
    output logic [`CPU_WIDTH-1:0]  ex_pc_o,
    output flow_e                  flow_as_o,
    output flow_e                  flow_wb_o
);

    logic [`CPU_WIDTH-1:0] pc;
    logic [`CPU_WIDTH-1:0] next_pc;
    logic                  next_pc_four;
    flow_e                 flow_pc;
    flow_e                 flow_de;
    flow_e                 flow_ex;
    fetch_pkt_t            if_pkt;
    fetch_pkt_t            de_pkt;
    exec_pkt_t             de_ex_pkt;    // decode side of u_de_ex
    exec_pkt_t             ex_pkt;
    logic                  zero;
    logic                  more_zero;
    logic                  less;

    // --------------------
    // fetch
    // --------------------
    pc_reg u_pc_reg (
        .clk_i          (clk_i),
        .arst_n_i       (arst_n_i),
        .flow_pc_i      (flow_pc),
        .next_pc_four_i (next_pc_four),
        .next_pc_i      (next_pc),
        .pc_o           (pc)
    );

    assign if_pkt = '{valid: (flow_pc == FLOW_WORK), pc: pc, inst: fetch_inst_i};

    pipe_stage #(.payload_t(fetch_pkt_t)) u_if_de (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .flow_i   (flow_de),
        .data_i   (if_pkt),
        .data_o   (de_pkt)
    );

    // --------------------
    // decode
    // --------------------
    assign de_ex_pkt = '{valid:  de_pkt.valid,
                         pc:     de_pkt.pc,
                         branch: de_branch_i,
                         jump:   de_jump_i,
                         imm:    de_imm_i,
                         rs1:    de_rs1_i,
                         rs2:    de_rs2_i};

    pipe_stage #(.payload_t(exec_pkt_t)) u_de_ex (
        .clk_i    (clk_i),
        .arst_n_i (arst_n_i),
        .flow_i   (flow_ex),
        .data_i   (de_ex_pkt),
        .data_o   (ex_pkt)
    );

    // --------------------
    // execute
    // --------------------
    branch_cmp u_branch_cmp (
        .rs1_i       (ex_pkt.rs1),
        .rs2_i       (ex_pkt.rs2),
        .branch_i    (ex_pkt.branch),
        .zero_o      (zero),
        .more_zero_o (more_zero),
        .less_o      (less)
    );

    flow_ctrl u_flow_ctrl (
        .jtag_halt_flag_i     (jtag_halt_flag_i),
        .bus_wait_i           (bus_wait_i),
        .alu_busy_i           (alu_busy_i),
        .access_mem_hold_i    (access_mem_hold_i),
        .pr_access_mem_flag_i (pr_access_mem_flag_i),
        .client_hold_flag_i   (client_hold_flag_i),
        .client_int_assert_i  (client_int_assert_i),
        .zero_i               (zero),
        .more_zero_i          (more_zero),
        .less_i               (less),
        .branch_i             (ex_pkt.branch),
        .jump_i               (ex_pkt.jump),
        .pc_adder_i           (ex_pkt.pc),
        .imm_i                (ex_pkt.imm),
        .reg1_rd_data_i       (ex_pkt.rs1),
        .client_int_addr_i    (client_int_addr_i),
        .next_pc_o            (next_pc),
        .next_pc_four_o       (next_pc_four),
        .flow_pc_o            (flow_pc),
        .flow_de_o            (flow_de),
        .flow_ex_o            (flow_ex),
        .flow_as_o            (flow_as_o),
        .flow_wb_o            (flow_wb_o)
    );

    assign pc_o       = pc;
    assign de_valid_o = de_pkt.valid;
    assign de_pc_o    = de_pkt.pc;
    assign de_inst_o  = de_pkt.inst;
    assign ex_valid_o = ex_pkt.valid;
    assign ex_pc_o    = ex_pkt.pc;

endmodule

// ==== tb_flow_top.sv ====
/*
 * directed testbench for the pipeline-control slice
 *   stage model driven by the expected stage actions
 *   compare tasks for pc words, instruction words, stage actions and single bits
 *   straight-line, branch, jump, stall, interrupt and halt tests
 *   watchdog and closing verdict
 */

`include "rooth_params.svh"

module tb_flow_top import rooth_pkg::*; ();

    localparam int CLK_PERIOD  = 40;
    localparam int TEST_CYCLES = 90;    // sum over all tests, about 84

    logic                   clk_i;
    logic                   arst_n_i;
    logic [`INST_WIDTH-1:0] fetch_inst_i;
    branch_e                de_branch_i;
    jump_e                  de_jump_i;
    logic [`CPU_WIDTH-1:0]  de_imm_i;
    logic [`CPU_WIDTH-1:0]  de_rs1_i;
    logic [`CPU_WIDTH-1:0]  de_rs2_i;
    logic                   jtag_halt_flag_i;
    logic                   bus_wait_i;
    logic                   alu_busy_i;
    logic                   access_mem_hold_i;
    logic                   pr_access_mem_flag_i;
    logic                   client_hold_flag_i;
    logic                   client_int_assert_i;
    logic [`CPU_WIDTH-1:0]  client_int_addr_i;
    logic [`CPU_WIDTH-1:0]  pc_o;
    logic                   de_valid_o;
    logic [`CPU_WIDTH-1:0]  de_pc_o;
    logic [`INST_WIDTH-1:0] de_inst_o;
    logic                   ex_valid_o;
    logic [`CPU_WIDTH-1:0]  ex_pc_o;
    flow_e                  flow_as_o;
    flow_e                  flow_wb_o;

    // expected register contents
    logic [`CPU_WIDTH-1:0]  m_pc;
    logic [`CPU_WIDTH-1:0]  m_de_pc;
    logic [`INST_WIDTH-1:0] m_de_inst;
    logic [`CPU_WIDTH-1:0]  m_ex_pc;
    logic                   m_de_v;
    logic                   m_ex_v;
    logic [31:0]            rng_state;
    int                     n_errors;
    int                     n_checks;
    branch_e                br_kinds [6] = '{BRANCH_BEQ, BRANCH_BNE, BRANCH_BLT,
                                             BRANCH_BGE, BRANCH_BLTU, BRANCH_BGEU};

    flow_top i_dut (.*);

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
    end

    // --------------------
    // helpers and model
    // --------------------
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic next_rand(output logic [31:0] v);
        rng_state = xorshift32(rng_state);
        v = rng_state;
    endtask

    function automatic logic branch_taken(input branch_e k, input logic [31:0] a, b);
        case (k)
            BRANCH_BEQ:  return a == b;
            BRANCH_BNE:  return a != b;
            BRANCH_BLT:  return $signed(a) < $signed(b);
            BRANCH_BGE:  return $signed(a) >= $signed(b);
            BRANCH_BLTU: return a < b;
            BRANCH_BGEU: return a >= b;
            default:     return 1'b0;
        endcase
    endfunction

    task automatic check_pc(input string name, input logic [`CPU_WIDTH-1:0] exp, act);
        n_checks++;
        if (act !== exp) begin
            n_errors++;
            $display("[ERROR] t=%0t %s expected 0x%08h got 0x%08h", $time, name, exp, act);
        end
    endtask

    task automatic check_inst(input string name, input logic [`INST_WIDTH-1:0] exp, act);
        n_checks++;
        if (act !== exp) begin
            n_errors++;
            $display("[ERROR] t=%0t %s expected 0x%08h got 0x%08h", $time, name, exp, act);
        end
    endtask

    task automatic check_flow(input string name, input flow_e exp, act);
        n_checks++;
        if (act !== exp) begin
            n_errors++;
            $display("[ERROR] t=%0t %s expected %s got %s", $time, name, exp.name(), act.name());
        end
    endtask

    task automatic check_bit(input string name, input logic exp, act);
        n_checks++;
        if (act !== exp) begin
            n_errors++;
            $display("[ERROR] t=%0t %s expected %b got %b", $time, name, exp, act);
        end
    endtask

    task automatic check_state();
        check_pc("pc_o", m_pc, pc_o);
        check_bit("de_valid_o", m_de_v, de_valid_o);
        check_pc("de_pc_o", m_de_pc, de_pc_o);
        check_inst("de_inst_o", m_de_inst, de_inst_o);
        check_bit("ex_valid_o", m_ex_v, ex_valid_o);
        check_pc("ex_pc_o", m_ex_pc, ex_pc_o);
    endtask

    // as / wb actions once the inputs of this cycle have settled
    task automatic check_actions(input flow_e e_as, e_wb);
        #5;
        check_flow("flow_as_o", e_as, flow_as_o);
        check_flow("flow_wb_o", e_wb, flow_wb_o);
    endtask

    // one clock edge; the model applies the expected actions, oldest stage first
    task automatic tick(input flow_e a_pc, a_de, a_ex, input logic redir,
                        input logic [`CPU_WIDTH-1:0] tgt);
        @(posedge clk_i);
        if (a_ex == FLOW_WORK) begin
            m_ex_v  = m_de_v;
            m_ex_pc = m_de_pc;
        end else if (a_ex == FLOW_REFRESH) begin
            m_ex_v  = 1'b0;
            m_ex_pc = '0;
        end
        if (a_de == FLOW_WORK) begin
            m_de_v    = (a_pc == FLOW_WORK);
            m_de_pc   = m_pc;
            m_de_inst = fetch_inst_i;
        end else if (a_de == FLOW_REFRESH) begin
            m_de_v    = 1'b0;
            m_de_pc   = '0;
            m_de_inst = '0;
        end
        if (a_pc == FLOW_WORK) begin
            m_pc = redir ? tgt : m_pc + `CPU_WIDTH'd4;
        end
        #2;    // inputs change here, registers are already settled
        next_rand(fetch_inst_i);    // new fetch word every cycle
        check_state();
    endtask

    task automatic clear_inputs();
        de_branch_i          = BRANCH_NONE;
        de_jump_i            = JUMP_NONE;
        de_imm_i             = '0;
        de_rs1_i             = '0;
        de_rs2_i             = '0;
        jtag_halt_flag_i     = 1'b0;
        bus_wait_i           = 1'b0;
        alu_busy_i           = 1'b0;
        access_mem_hold_i    = 1'b0;
        pr_access_mem_flag_i = 1'b0;
        client_hold_flag_i   = 1'b0;
        client_int_assert_i  = 1'b0;
        client_int_addr_i    = '0;
    endtask

    task automatic run_straight(input int n);
        repeat (n) begin
            check_actions(FLOW_WORK, FLOW_WORK);
            tick(FLOW_WORK, FLOW_WORK, FLOW_WORK, 1'b0, '0);
        end
    endtask

    // --------------------
    // tests
    // --------------------
    task automatic test_branch(input branch_e kind);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] r;
        logic [31:0] imm;
        logic        taken;
        flow_e       flush;
        next_rand(a);
        next_rand(b);
        next_rand(r);
        if (r[0]) b = a;    // equal operands now and then
        imm = {{20{r[11]}}, r[11:2], 2'b00};
        de_branch_i = kind;
        de_imm_i    = imm;
        de_rs1_i    = a;
        de_rs2_i    = b;
        check_actions(FLOW_WORK, FLOW_WORK);
        tick(FLOW_WORK, FLOW_WORK, FLOW_WORK, 1'b0, '0);
        clear_inputs();
        taken = branch_taken(kind, a, b);
        flush = taken ? FLOW_REFRESH : FLOW_WORK;
        check_actions(FLOW_WORK, FLOW_WORK);
        tick(FLOW_WORK, flush, flush, taken, m_ex_pc + imm);
        run_straight(1);
    endtask

    task automatic test_jump(input jump_e kind);
        logic [31:0] r;
        logic [31:0] rs1;
        logic [31:0] imm;
        logic [31:0] tgt;
        next_rand(rs1);
        next_rand(r);
        rs1 = rs1 & 32'hffff_fffc;
        imm = {{20{r[11]}}, r[11:2], 2'b00};
        de_jump_i = kind;
        de_imm_i  = imm;
        de_rs1_i  = rs1;
        check_actions(FLOW_WORK, FLOW_WORK);
        tick(FLOW_WORK, FLOW_WORK, FLOW_WORK, 1'b0, '0);
        clear_inputs();
        case (kind)
            JUMP_JAL:  tgt = m_ex_pc + imm;
            JUMP_JALR: tgt = rs1 + imm;
            default:   tgt = m_ex_pc + 32'd4;    // fence refetch
        endcase
        check_actions(FLOW_WORK, FLOW_WORK);
        tick(FLOW_WORK, FLOW_REFRESH, FLOW_REFRESH, 1'b1, tgt);
        run_straight(1);
    endtask

    task automatic set_stall(input int sel, input logic lvl);
        case (sel)
            0:       client_hold_flag_i   = lvl;
            1:       access_mem_hold_i    = lvl;
            2:       pr_access_mem_flag_i = lvl;
            3:       alu_busy_i           = lvl;
            default: bus_wait_i           = lvl;
        endcase
    endtask

    // one stall level alone for three cycles, pc always stops
    task automatic test_stall(input int sel, input flow_e e_de, e_ex, e_as, e_wb);
        set_stall(sel, 1'b1);
        repeat (3) begin
            check_actions(e_as, e_wb);
            tick(FLOW_STOP, e_de, e_ex, 1'b0, '0);
        end
        set_stall(sel, 1'b0);
        run_straight(2);
    endtask

    task automatic test_interrupt();
        logic [31:0] addr;
        next_rand(addr);
        addr = addr & 32'hffff_fffc;
        jtag_halt_flag_i     = 1'b1;
        bus_wait_i           = 1'b1;
        alu_busy_i           = 1'b1;
        access_mem_hold_i    = 1'b1;
        pr_access_mem_flag_i = 1'b1;
        client_hold_flag_i   = 1'b1;
        client_int_assert_i  = 1'b1;
        client_int_addr_i    = addr;
        check_actions(FLOW_REFRESH, FLOW_REFRESH);
        tick(FLOW_WORK, FLOW_REFRESH, FLOW_REFRESH, 1'b1, addr);
        clear_inputs();
        run_straight(1);
    endtask

    task automatic test_halt();
        logic [31:0] a;
        logic [31:0] imm;
        jtag_halt_flag_i = 1'b1;
        repeat (2) begin
            check_actions(FLOW_STOP, FLOW_STOP);
            tick(FLOW_STOP, FLOW_STOP, FLOW_STOP, 1'b0, '0);
        end
        jtag_halt_flag_i = 1'b0;
        run_straight(1);
        // taken beq in execute while halt is high
        next_rand(a);
        imm = 32'h0000_0040;
        de_branch_i = BRANCH_BEQ;
        de_imm_i    = imm;
        de_rs1_i    = a;
        de_rs2_i    = a;
        check_actions(FLOW_WORK, FLOW_WORK);
        tick(FLOW_WORK, FLOW_WORK, FLOW_WORK, 1'b0, '0);
        clear_inputs();
        jtag_halt_flag_i = 1'b1;
        check_actions(FLOW_WORK, FLOW_WORK);
        tick(FLOW_WORK, FLOW_REFRESH, FLOW_REFRESH, 1'b1, m_ex_pc + imm);
        jtag_halt_flag_i = 1'b0;
        run_straight(1);
    endtask

    // --------------------
    // main sequence
    // --------------------
    initial begin
        n_errors     = 0;
        n_checks     = 0;
        rng_state    = 32'h8f351d83;
        fetch_inst_i = 32'h0000_0013;    // addi x0, x0, 0
        arst_n_i     = 1'b0;
        clear_inputs();
        m_pc      = `RESET_PC;
        m_de_pc   = '0;
        m_de_inst = '0;
        m_ex_pc   = '0;
        m_de_v    = 1'b0;
        m_ex_v    = 1'b0;
        repeat (2) @(posedge clk_i);
        #2 arst_n_i = 1'b1;
        check_state();
        run_straight(6);
        foreach (br_kinds[i]) begin
            repeat (2) test_branch(br_kinds[i]);
        end
        test_jump(JUMP_JAL);
        test_jump(JUMP_JALR);
        test_jump(JUMP_FENCE);
        test_stall(0, FLOW_STOP, FLOW_STOP, FLOW_STOP, FLOW_STOP);
        test_stall(1, FLOW_STOP, FLOW_STOP, FLOW_STOP, FLOW_REFRESH);
        test_stall(2, FLOW_STOP, FLOW_REFRESH, FLOW_WORK, FLOW_WORK);
        test_stall(3, FLOW_STOP, FLOW_STOP, FLOW_REFRESH, FLOW_WORK);
        test_stall(4, FLOW_REFRESH, FLOW_WORK, FLOW_WORK, FLOW_WORK);
        test_interrupt();
        test_halt();
        $display("checks: %0d  errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        #((TEST_CYCLES + 20) * CLK_PERIOD);
        $display("timeout: the tests did not finish in %0d cycles", TEST_CYCLES + 20);
        $display("Simulation failed");
        $finish;
    end

endmodule

// ==== list.f ====
+incdir+.
rooth_pkg.sv
branch_cmp.sv
flow_ctrl.sv
pc_reg.sv
pipe_stage.sv
flow_top.sv
tb_flow_top.sv

// ==== run.sh ====
#!/bin/sh
# compile and run the flow_top testbench with verilator

verilator --binary --timing --assert -f list.f --top-module tb_flow_top \
    -o tb_flow_top > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/tb_flow_top > sim.log 2>&1
cat sim.log

grep -q "Simulation failed" sim.log && { echo "FAIL"; exit 1; } || true
grep -q "Simulation completed successfully" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
